//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;       // insn, immediate or data word
    typedef logic [4:0]  reg_addr_t;   // register number
    typedef logic [6:0]  opcode_t;
    typedef logic [7:0]  alu_op_t;
    typedef logic [3:0]  cond_t;
    typedef logic [3:0]  flag_mask_t;  // one bit per flag written

    typedef enum logic [1:0] {
        mem_pass,   // no memory access
        mem_read,
        mem_write
    } mem_op_t;

    localparam opcode_t op_nop  = 7'd0;
    localparam opcode_t op_or   = 7'd1;
    localparam opcode_t op_nor  = 7'd2;
    localparam opcode_t op_and  = 7'd3;
    localparam opcode_t op_nand = 7'd4;
    localparam opcode_t op_inv  = 7'd5;
    localparam opcode_t op_xor  = 7'd6;
    localparam opcode_t op_lsl  = 7'd7;
    localparam opcode_t op_lsr  = 7'd8;
    localparam opcode_t op_asr  = 7'd9;
    localparam opcode_t op_asl  = 7'd10;
    localparam opcode_t op_csr  = 7'd11;   // rotate right
    localparam opcode_t op_csl  = 7'd12;   // rotate left
    localparam opcode_t op_add  = 7'd13;
    localparam opcode_t op_sub  = 7'd14;
    localparam opcode_t op_mull = 7'd15;   // low half of product
    localparam opcode_t op_csg  = 7'd18;   // change sign
    localparam opcode_t op_inc  = 7'd19;
    localparam opcode_t op_dec  = 7'd20;
    localparam opcode_t op_cmp  = 7'd21;
    localparam opcode_t op_cmn  = 7'd22;
    localparam opcode_t op_tst  = 7'd23;
    localparam opcode_t op_br   = 7'd24;
    localparam opcode_t op_ldr  = 7'd28;
    localparam opcode_t op_str  = 7'd29;
    localparam opcode_t op_movs = 7'd32;

    localparam alu_op_t alu_nop  = 8'h00;
    localparam alu_op_t alu_add  = 8'h01;
    localparam alu_op_t alu_sub  = 8'h02;
    localparam alu_op_t alu_cpl  = 8'h03;  // two's complement
    localparam alu_op_t alu_mul  = 8'h04;
    localparam alu_op_t alu_shr  = 8'h05;
    localparam alu_op_t alu_shl  = 8'h06;
    localparam alu_op_t alu_sar  = 8'h07;
    localparam alu_op_t alu_sal  = 8'h08;
    localparam alu_op_t alu_ror  = 8'h09;
    localparam alu_op_t alu_rol  = 8'h0a;
    localparam alu_op_t alu_not  = 8'h0b;
    localparam alu_op_t alu_and  = 8'h0c;
    localparam alu_op_t alu_or   = 8'h0d;
    localparam alu_op_t alu_xor  = 8'h0e;
    localparam alu_op_t alu_nand = 8'h0f;
    localparam alu_op_t alu_nor  = 8'h10;

    localparam int opcode_lsb = 25;   // low bit of each insn field
    localparam int cond_lsb   = 21;
    localparam int ra_lsb     = 16;
    localparam int rb_lsb     = 11;
    localparam int rc_lsb     = 6;
    localparam int imm_a_bit  = 5;    // immediate replaces ra
    localparam int imm_b_bit  = 4;    // immediate replaces rb

    localparam reg_addr_t pc_reg = 5'd31;
    localparam int num_writers   = 3;  // ex, mem, wb

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // insn word with its immediates, as gathered by the assembler
    typedef struct packed {
        isa_pkg::word_t insn;
        isa_pkg::word_t imm_a;
        isa_pkg::word_t imm_b;
        logic           has_imm_a;
        logic           has_imm_b;   // never set for ldr/str
    } raw_insn_t;

    typedef struct packed {
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::cond_t      cond;
        logic                is_cond;
        isa_pkg::flag_mask_t write_flags;
        isa_pkg::mem_op_t    mem_op;
        logic                rd_valid;     // writes a register
        isa_pkg::reg_addr_t  rd;           // destination
        isa_pkg::reg_addr_t  ra;
        isa_pkg::reg_addr_t  rb;
        logic                rd_a;         // ra read from the register file
        logic                rd_b;
        logic                use_imm_a;
        logic                use_imm_b;
        logic                force_b_one;  // inc/dec
        logic                is_branch;
        isa_pkg::word_t      imm_a;
        isa_pkg::word_t      imm_b;
    } ctrl_t;

    typedef struct packed {
        isa_pkg::alu_op_t    alu_op;
        isa_pkg::cond_t      cond;
        logic                is_cond;
        isa_pkg::flag_mask_t write_flags;
        isa_pkg::mem_op_t    mem_op;
        logic                rd_valid;
        isa_pkg::reg_addr_t  rd;
        logic                is_branch;
        isa_pkg::word_t      op_a;   // address for ldr/str
        isa_pkg::word_t      op_b;   // store data for str
    } issue_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t addr;
    } writer_t;

    typedef writer_t [isa_pkg::num_writers-1:0] writers_t;  // [0] ex, [1] mem, [2] wb

endpackage

`default_nettype wire

//--- hw/insn_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module insn_assembler (
    input  logic                clk,
    input  logic                rst,
    input  logic                word_valid,
    output logic                word_ready,
    input  isa_pkg::word_t      word,
    output logic                raw_valid,
    input  logic                raw_ready,
    output pipe_pkg::raw_insn_t raw
);
    import isa_pkg::*;

    typedef enum logic [1:0] {
        st_insn,   // expecting an opcode word
        st_imm1,
        st_imm2,
        st_full    // bundle waiting for decode
    } state_t;

    state_t  state;
    logic    word_fire;
    logic    take_insn;
    opcode_t word_op;
    logic    want_a;
    logic    want_b;

    // a full bundle can be replaced in the cycle it leaves
    assign word_ready = (state != st_full) || raw_ready;
    assign word_fire  = word_valid && word_ready;
    assign take_insn  = word_fire && (state == st_insn || state == st_full);
    assign raw_valid  = (state == st_full);

    assign word_op = word[opcode_lsb +: $bits(opcode_t)];
    assign want_a  = word[imm_a_bit];
    assign want_b  = word[imm_b_bit] && !(word_op == op_ldr || word_op == op_str);  // mem ops take one imm

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_insn;
        end else begin
            case (state)
                st_insn, st_full: begin
                    if (take_insn) begin
                        state <= (want_a || want_b) ? st_imm1 : st_full;
                    end else if (raw_ready) begin
                        state <= st_insn;  // bundle gone, nothing new
                    end
                end
                st_imm1: begin
                    if (word_fire) begin
                        state <= (raw.has_imm_a && raw.has_imm_b) ? st_imm2 : st_full;
                    end
                end
                st_imm2: begin
                    if (word_fire) begin
                        state <= st_full;
                    end
                end
                default: state <= st_insn;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_insn) begin
            raw.insn      <= word;
            raw.has_imm_a <= want_a;
            raw.has_imm_b <= want_b;
        end else if (word_fire && state == st_imm1) begin
            if (raw.has_imm_a) begin
                raw.imm_a <= word;  // first imm belongs to a when both set
            end else begin
                raw.imm_b <= word;
            end
        end else if (word_fire && state == st_imm2) begin
            raw.imm_b <= word;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                raw_valid,
    output logic                raw_ready,
    input  pipe_pkg::raw_insn_t raw,
    output logic                ctl_valid,
    input  logic                ctl_ready,
    output pipe_pkg::ctrl_t     ctl
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t opcode;
    alu_op_t alu;
    mem_op_t mem;
    logic    active;     // kept, non-nop opcode
    logic    has_b;
    logic    wr_c;
    logic    flags_on;
    logic    branch;
    logic    force_one;
    ctrl_t   ctl_d;

    assign opcode = raw.insn[opcode_lsb +: $bits(opcode_t)];

    always_comb begin
        alu       = alu_nop;
        mem       = mem_pass;
        active    = 1'b1;
        has_b     = 1'b1;
        wr_c      = 1'b1;
        flags_on  = 1'b1;
        branch    = 1'b0;
        force_one = 1'b0;
        case (opcode)
            op_or:   alu = alu_or;
            op_nor:  alu = alu_nor;
            op_and:  alu = alu_and;
            op_nand: alu = alu_nand;
            op_xor:  alu = alu_xor;
            op_lsl:  alu = alu_shl;
            op_lsr:  alu = alu_shr;
            op_asr:  alu = alu_sar;
            op_asl:  alu = alu_sal;
            op_csr:  alu = alu_ror;
            op_csl:  alu = alu_rol;
            op_add:  alu = alu_add;
            op_sub:  alu = alu_sub;
            op_mull: alu = alu_mul;
            op_inv, op_csg: begin
                alu   = (opcode == op_inv) ? alu_not : alu_cpl;
                has_b = 1'b0;
            end
            op_inc, op_dec: begin
                alu       = (opcode == op_inc) ? alu_add : alu_sub;
                has_b     = 1'b0;
                force_one = 1'b1;  // b operand fixed at 1
            end
            op_cmp: begin
                alu  = alu_sub;
                wr_c = 1'b0;
            end
            op_cmn: begin
                alu  = alu_add;
                wr_c = 1'b0;
            end
            op_tst: begin
                alu  = alu_and;
                wr_c = 1'b0;
            end
            op_br: begin
                has_b    = 1'b0;
                flags_on = 1'b0;
                branch   = 1'b1;  // fetch redirect is downstream
            end
            op_ldr: begin
                mem      = mem_read;
                has_b    = 1'b0;
                flags_on = 1'b0;
            end
            op_str: begin
                mem      = mem_write;  // a address, b data
                wr_c     = 1'b0;
                flags_on = 1'b0;
            end
            op_movs: begin
                has_b    = 1'b0;
                flags_on = 1'b0;
            end
            op_nop:  active = 1'b0;
            default: active = 1'b0;  // unknown issues as nop
        endcase

        ctl_d             = '0;
        ctl_d.alu_op      = alu;
        ctl_d.mem_op      = mem;
        ctl_d.is_cond     = active;
        ctl_d.cond        = active ? raw.insn[cond_lsb +: $bits(cond_t)] : '0;
        ctl_d.write_flags = (active && flags_on) ? '1 : '0;
        ctl_d.rd_valid    = active && wr_c;
        ctl_d.rd          = branch ? pc_reg : raw.insn[rc_lsb +: $bits(reg_addr_t)];
        ctl_d.ra          = raw.insn[ra_lsb +: $bits(reg_addr_t)];
        ctl_d.rb          = raw.insn[rb_lsb +: $bits(reg_addr_t)];
        ctl_d.rd_a        = active && !raw.has_imm_a;  // imm replaces the read
        ctl_d.rd_b        = active && has_b && !raw.has_imm_b;
        ctl_d.use_imm_a   = active && raw.has_imm_a;
        ctl_d.use_imm_b   = active && has_b && raw.has_imm_b;
        ctl_d.force_b_one = force_one;
        ctl_d.is_branch   = branch;
        ctl_d.imm_a       = raw.imm_a;
        ctl_d.imm_b       = raw.imm_b;
    end

    assign raw_ready = !ctl_valid || ctl_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctl_valid <= 1'b0;
        end else if (raw_valid && raw_ready) begin
            ctl_valid <= 1'b1;
        end else if (ctl_ready) begin
            ctl_valid <= 1'b0;  // drained
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid && raw_ready) begin
            ctl <= ctl_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_hazard_checker.sv
`timescale 1ns/1ps
`default_nettype none

module reg_hazard_checker (
    input  pipe_pkg::writers_t  writers,
    input  isa_pkg::reg_addr_t  ra,
    input  isa_pkg::reg_addr_t  rb,
    input  logic                rd_a,
    input  logic                rd_b,
    output logic                hazard
);
    import isa_pkg::*;

    logic [num_writers-1:0] match_a;  // per writer, ex first
    logic [num_writers-1:0] match_b;

    always_comb begin
        for (int i = 0; i < num_writers; i++) begin
            match_a[i] = writers[i].valid && (writers[i].addr == ra);
            match_b[i] = writers[i].valid && (writers[i].addr == rb);
        end
    end

    // only sources actually read from the register file can collide
    assign hazard = (rd_a && |match_a) || (rd_b && |match_b);

endmodule

`default_nettype wire

//--- hw/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ctl_valid,
    output logic               ctl_ready,
    input  pipe_pkg::ctrl_t    ctl,
    output isa_pkg::reg_addr_t rf_addr_a,
    output isa_pkg::reg_addr_t rf_addr_b,
    input  isa_pkg::word_t     rf_data_a,
    input  isa_pkg::word_t     rf_data_b,
    input  logic               hazard,
    output logic               issue_valid,
    input  logic               issue_ready,
    output pipe_pkg::issue_t   issue
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t  op_a;
    word_t  op_b;
    issue_t issue_d;
    logic   ctl_fire;

    // read port follows the word held in decode
    assign rf_addr_a = ctl.ra;
    assign rf_addr_b = ctl.rb;

    assign ctl_ready = (!issue_valid || issue_ready) && !hazard;  // hold on hazard
    assign ctl_fire  = ctl_valid && ctl_ready;

    always_comb begin
        if (ctl.use_imm_a) begin
            op_a = ctl.imm_a;
        end else if (ctl.rd_a) begin
            op_a = rf_data_a;
        end else begin
            op_a = '0;
        end

        if (ctl.force_b_one) begin
            op_b = word_t'(1);
        end else if (ctl.use_imm_b) begin
            op_b = ctl.imm_b;
        end else if (ctl.rd_b) begin
            op_b = rf_data_b;
        end else begin
            op_b = '0;  // single source
        end
    end

    always_comb begin
        issue_d.alu_op      = ctl.alu_op;
        issue_d.cond        = ctl.cond;
        issue_d.is_cond     = ctl.is_cond;
        issue_d.write_flags = ctl.write_flags;
        issue_d.mem_op      = ctl.mem_op;
        issue_d.rd_valid    = ctl.rd_valid;
        issue_d.rd          = ctl.rd;
        issue_d.is_branch   = ctl.is_branch;
        issue_d.op_a        = op_a;
        issue_d.op_b        = op_b;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (ctl_fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_fire) begin
            issue <= issue_d;  // held while issue_ready low
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_valid,
    output logic               word_ready,
    input  isa_pkg::word_t     word,
    output logic               issue_valid,
    input  logic               issue_ready,
    output pipe_pkg::issue_t   issue,
    output isa_pkg::reg_addr_t rf_addr_a,
    output isa_pkg::reg_addr_t rf_addr_b,
    input  isa_pkg::word_t     rf_data_a,
    input  isa_pkg::word_t     rf_data_b,
    input  pipe_pkg::writers_t writers
);
    import pipe_pkg::*;

    logic      raw_valid;
    logic      raw_ready;
    raw_insn_t raw;
    logic      ctl_valid;
    logic      ctl_ready;
    ctrl_t     ctl;
    logic      hazard;

    insn_assembler i_insn_assembler (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word       (word),
        .raw_valid  (raw_valid),
        .raw_ready  (raw_ready),
        .raw        (raw)
    );

    decode_stage i_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .raw_valid (raw_valid),
        .raw_ready (raw_ready),
        .raw       (raw),
        .ctl_valid (ctl_valid),
        .ctl_ready (ctl_ready),
        .ctl       (ctl)
    );

    // sources of the word waiting in decode
    reg_hazard_checker i_reg_hazard_checker (
        .writers (writers),
        .ra      (rf_addr_a),
        .rb      (rf_addr_b),
        .rd_a    (ctl.rd_a),
        .rd_b    (ctl.rd_b),
        .hazard  (hazard)
    );

    operand_stage i_operand_stage (
        .clk         (clk),
        .rst         (rst),
        .ctl_valid   (ctl_valid),
        .ctl_ready   (ctl_ready),
        .ctl         (ctl),
        .rf_addr_a   (rf_addr_a),
        .rf_addr_b   (rf_addr_b),
        .rf_data_a   (rf_data_a),
        .rf_data_b   (rf_data_b),
        .hazard      (hazard),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue)
    );

endmodule

`default_nettype wire

//--- dv/cpu_decode_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode_properties (
    input logic             clk,
    input logic             rst,
    input logic             ctl_valid,
    input logic             ctl_ready,
    input pipe_pkg::ctrl_t  ctl,
    input logic             hazard,
    input logic             issue_valid,
    input logic             issue_ready,
    input pipe_pkg::issue_t issue
);

    int fails = 0;

    // stalled packet stays put until taken
    a_issue_hold: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else begin
            fails++;
            $error("issue output changed or dropped while stalled");
        end

    // decode output held while operand stage refuses it
    a_ctl_hold: assert property (@(posedge clk) disable iff (rst)
        ctl_valid && !ctl_ready |=> ctl_valid && $stable(ctl))
        else begin
            fails++;
            $error("decode output changed or dropped while stalled");
        end

    // no new packet loaded while a source is pending
    a_hazard_blocks: assert property (@(posedge clk) disable iff (rst)
        ctl_valid && hazard |=> !$rose(issue_valid) && (!issue_valid || $stable(issue)))
        else begin
            fails++;
            $error("operand stage issued an instruction during a hazard");
        end

    a_reset_clears: assert property (@(posedge clk)
        rst |=> !issue_valid)
        else begin
            fails++;
            $error("issue_valid high right after reset");
        end

endmodule

`default_nettype wire

//--- dv/tb_cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_decode;
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic      rd_a;
        reg_addr_t ra;
        logic      rd_b;
        reg_addr_t rb;
    } reads_t;  // sources a packet takes from the register file

    localparam int n_sweep  = 112;  // 26 kept + 2 unknown ops, four imm patterns each
    localparam int n_random = 400;
    localparam int limit_ns = (n_sweep + n_random) * 40;

    logic      clk;
    logic      rst;
    logic      word_valid;
    logic      word_ready;
    word_t     word;
    logic      issue_valid;
    logic      issue_ready;
    issue_t    issue;
    reg_addr_t rf_addr_a;
    reg_addr_t rf_addr_b;
    word_t     rf_data_a;
    word_t     rf_data_b;
    writers_t  writers;

    opcode_t kept_ops [26] = '{op_nop, op_or, op_nor, op_and, op_nand, op_inv, op_xor,
                               op_lsl, op_lsr, op_asr, op_asl, op_csr, op_csl, op_add,
                               op_sub, op_mull, op_csg, op_inc, op_dec, op_cmp, op_cmn,
                               op_tst, op_br, op_ldr, op_str, op_movs};
    word_t       words[$];   // program stream, insns and imms
    issue_t      exp_q[$];   // predicted packets in program order
    reads_t      src_q[$];
    int          widx;
    int          issued;
    int          errors;
    int          checks;
    bit          pressure;   // random stalls on both sides
    bit          held_prev;
    issue_t      held_issue;
    writers_t    prev_writers;
    string       test_name;

    cpu_decode_top i_cpu_decode_top (.*);

    bind operand_stage cpu_decode_properties i_cpu_decode_properties (.*);

    always #2 clk = ~clk;

    function automatic word_t reg_value(input reg_addr_t addr);
        return 32'h9e3779b9 * (word_t'(addr) + 32'd1);  // fixed per register
    endfunction

    assign rf_data_a = reg_value(rf_addr_a);  // combinational read port
    assign rf_data_b = reg_value(rf_addr_b);

    function automatic logic blocked(input reads_t r, input writers_t w);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < num_writers; i++) begin
            if (w[i].valid && ((r.rd_a && w[i].addr == r.ra) || (r.rd_b && w[i].addr == r.rb))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // reference decoder, straight from the opcode table
    task automatic predict(input word_t insn, input word_t imm_a, input word_t imm_b,
                           input logic ha, input logic hb);
        issue_t  p;
        reads_t  r;
        opcode_t op;
        logic    kept;
        logic    src_b;
        op    = insn[opcode_lsb +: 7];
        p     = '0;
        r     = '0;
        kept  = 1'b1;
        case (op)
            op_or:                        p.alu_op = alu_or;
            op_nor:                       p.alu_op = alu_nor;
            op_and, op_tst:               p.alu_op = alu_and;
            op_nand:                      p.alu_op = alu_nand;
            op_inv:                       p.alu_op = alu_not;
            op_xor:                       p.alu_op = alu_xor;
            op_lsl:                       p.alu_op = alu_shl;
            op_lsr:                       p.alu_op = alu_shr;
            op_asr:                       p.alu_op = alu_sar;
            op_asl:                       p.alu_op = alu_sal;
            op_csr:                       p.alu_op = alu_ror;
            op_csl:                       p.alu_op = alu_rol;
            op_add, op_inc, op_cmn:       p.alu_op = alu_add;
            op_sub, op_dec, op_cmp:       p.alu_op = alu_sub;
            op_mull:                      p.alu_op = alu_mul;
            op_csg:                       p.alu_op = alu_cpl;
            op_br, op_ldr, op_str, op_movs: p.alu_op = alu_nop;
            default:                      kept = 1'b0;  // nop and unknown
        endcase
        src_b = !(op inside {op_inv, op_csg, op_inc, op_dec, op_br, op_ldr, op_movs});
        if (kept) begin
            p.is_cond     = 1'b1;
            p.cond        = insn[cond_lsb +: 4];
            p.write_flags = (op inside {op_br, op_ldr, op_str, op_movs}) ? 4'h0 : 4'hf;
            p.mem_op      = (op == op_ldr) ? mem_read : (op == op_str) ? mem_write : mem_pass;
            p.is_branch   = (op == op_br);
            p.rd_valid    = !(op inside {op_cmp, op_cmn, op_tst, op_str});
            p.rd          = p.is_branch ? pc_reg : insn[rc_lsb +: 5];
            r.ra          = insn[ra_lsb +: 5];
            r.rb          = insn[rb_lsb +: 5];
            r.rd_a        = !ha;
            r.rd_b        = src_b && !hb;
            p.op_a        = ha ? imm_a : reg_value(r.ra);
            if (op == op_inc || op == op_dec) begin
                p.op_b = 32'd1;
            end else if (src_b) begin
                p.op_b = hb ? imm_b : reg_value(r.rb);
            end
            if (!p.rd_valid) begin
                p.rd = '0;  // destination unused
            end
        end
        exp_q.push_back(p);
        src_q.push_back(r);
    endtask

    task automatic build_program(input int mode, input int n);
        word_t   w;
        word_t   ia;
        word_t   ib;
        opcode_t op;
        logic    fa;
        logic    fb;
        for (int i = 0; i < n; i++) begin
            if (mode == 0) begin
                op = (i / 4 < 26) ? kept_ops[i / 4] : opcode_t'(40 + i / 4);
                fa = (i % 2 == 1);  // none, a, b, both
                fb = (i % 4 >= 2);
            end else begin
                op = ($urandom_range(7) == 0) ? opcode_t'($urandom_range(127, 33))
                                              : kept_ops[$urandom_range(25)];
                fa = 1'($urandom_range(1));
                fb = 1'($urandom_range(1));
            end
            w                  = $urandom;
            w[opcode_lsb +: 7] = op;
            w[imm_a_bit]       = fa;
            w[imm_b_bit]       = fb;
            ia                 = $urandom;
            ib                 = $urandom;
            if (op == op_ldr || op == op_str) begin
                fb = 1'b0;  // b flag left set in the word, no imm follows
            end
            words.push_back(w);
            if (fa) begin
                words.push_back(ia);
            end
            if (fb) begin
                words.push_back(ib);
            end
            predict(w, ia, ib, fa, fb);
        end
    endtask

    task automatic run_program(input string name, input int mode, input int n, input bit bp);
        int start_err;
        @(negedge clk);
        start_err = errors;
        test_name = name;
        words.delete();
        widx      = 0;
        issued    = 0;
        pressure  = bp;
        build_program(mode, n);
        while (issued < n) begin
            @(posedge clk);
        end
        $display("test %s: %s, %0d errors", name, (errors == start_err) ? "ok" : "FAILED",
                 errors - start_err);
    endtask

    always @(posedge clk) begin : drive
        writer_t fresh;
        if (word_valid && word_ready) begin
            widx++;
        end
        if (!word_valid || word_ready) begin  // valid only drops after a transfer
            if (widx < words.size() && (!pressure || $urandom_range(3) != 0)) begin
                word_valid <= 1'b1;
                word       <= words[widx];
            end else begin
                word_valid <= 1'b0;
            end
        end
        fresh = '0;
        if (issue_valid && issue_ready && issue.rd_valid) begin
            fresh.valid = 1'b1;  // issued dest enters ex
            fresh.addr  = issue.rd;
        end else if ($urandom_range(7) == 0) begin
            fresh.valid = 1'b1;
            fresh.addr  = reg_addr_t'($urandom_range(31));
        end
        writers     <= {writers[1], writers[0], fresh};
        issue_ready <= !pressure || ($urandom_range(2) != 0);
    end

    always @(posedge clk) begin : monitor
        issue_t act;
        if (!rst) begin
            // new packet was loaded on the previous edge
            if (issue_valid && !held_prev && src_q.size() > 0) begin
                assert (!blocked(src_q[0], prev_writers)) else begin
                    errors++;
                    $display("%s: packet %0d issued while a pending writer matched a source",
                             test_name, issued);
                end
            end
            if (held_prev) begin
                assert (issue_valid && issue === held_issue) else begin
                    errors++;
                    $display("%s: issue changed or dropped while issue_ready was low", test_name);
                end
            end
            if (issue_valid && issue_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("%s: packet issued with no instruction pending", test_name);
                end
                if (exp_q.size() > 0) begin
                    act = issue;
                    if (!act.rd_valid) begin
                        act.rd = '0;
                    end
                    checks++;
                    assert (act === exp_q[0]) else begin
                        errors++;
                        $display("MISMATCH %s packet %0d: expected %h actual %h",
                                 test_name, issued, exp_q[0], act);
                    end
                    void'(exp_q.pop_front());
                    void'(src_q.pop_front());
                    issued++;
                end
            end
        end
        held_prev    = !rst && issue_valid && !issue_ready;
        held_issue   = issue;
        prev_writers = writers;
    end

    initial begin
        void'($urandom(32'h5b21));
        clk         = 1'b0;
        rst         = 1'b1;
        word_valid  = 1'b0;
        word        = '0;
        issue_ready = 1'b0;
        writers     = '0;
        pressure    = 1'b0;
        held_prev   = 1'b0;
        widx        = 0;
        issued      = 0;
        errors      = 0;
        checks      = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_name = "reset_state";
        assert (!issue_valid && word_ready) else begin
            errors++;
            $display("reset_state: issue_valid not low or word_ready not high after reset");
        end
        $display("test reset_state: %s", (errors == 0) ? "ok" : "FAILED");
        run_program("opcode_sweep", 0, n_sweep, 1'b0);   // straight after reset
        run_program("random_stream", 1, n_random, 1'b1);
        repeat (10) @(posedge clk);  // late duplicates would show here
        errors += i_cpu_decode_top.i_operand_stage.i_cpu_decode_properties.fails;
        $display("tests: 3, packets checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/insn_assembler.sv
hw/decode_stage.sv
hw/reg_hazard_checker.sv
hw/operand_stage.sv
hw/cpu_decode_top.sv
dv/cpu_decode_properties.sv
dv/tb_cpu_decode.sv

//--- Bender.yml
package:
  name: cpu_decode

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/insn_assembler.sv
      - hw/decode_stage.sv
      - hw/reg_hazard_checker.sv
      - hw/operand_stage.sv
      - hw/cpu_decode_top.sv
  - target: test
    files:
      - dv/cpu_decode_properties.sv
      - dv/tb_cpu_decode.sv
